//--- verilog/mips_pkg.sv
// mips core package: word types, opcode and funct codes, alu ops and control structs
`default_nettype none

package mips_pkg;

   // basic widths
   typedef logic [31:0] word_t;
   typedef logic [29:0] word_addr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [4:0]  shamt_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   // primary opcodes of the kept instructions
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_J     = 6'h02;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_BNE   = 6'h05;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_ANDI  = 6'h0c;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_LUI   = 6'h0f;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;

   // funct codes under OP_RTYPE
   localparam funct_t FN_SLL     = 6'h00;
   localparam funct_t FN_SRL     = 6'h02;
   localparam funct_t FN_SRA     = 6'h03;
   localparam funct_t FN_SYSCALL = 6'h0c;
   localparam funct_t FN_ADDU    = 6'h21;
   localparam funct_t FN_SUBU    = 6'h23;
   localparam funct_t FN_AND     = 6'h24;
   localparam funct_t FN_OR      = 6'h25;
   localparam funct_t FN_XOR     = 6'h26;
   localparam funct_t FN_NOR     = 6'h27;
   localparam funct_t FN_SLT     = 6'h2a;

   // alu operation select
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   // next pc choice
   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BEQ,
      PC_BNE,
      PC_JUMP
   } pc_sel_e;

   // decoded control, 54 bits
   // imm carries the 26-bit jump target, zero extended, for j
   typedef struct packed {
      alu_op_e  alu_op;
      logic     alu_src_imm;
      logic     imm_sign_extend;
      logic     reg_write;
      reg_idx_t wr_reg;
      logic     mem_read;
      logic     mem_write;
      pc_sel_e  pc_sel;
      logic     halt_req;
      word_t    imm;
      shamt_t   shamt;
   } ctrl_t;

   // data memory request, 63 bits
   typedef struct packed {
      word_addr_t addr;
      word_t      wdata;
      logic       write;
   } dmem_req_t;

endpackage

`default_nettype wire

//--- verilog/mips_alu.sv
// integer alu: add/sub, logic ops, signed compare, shifts by shamt and lui
`default_nettype none
`timescale 1ns/1ps

module mips_alu (
   input  mips_pkg::ctrl_t ctrl,
   input  mips_pkg::word_t rs_data,
   input  mips_pkg::word_t rt_data,
   output mips_pkg::word_t result
);

   mips_pkg::word_t op_b;
   logic            less_signed;

   // second operand is either rt or the extended immediate
   assign op_b = ctrl.alu_src_imm ? ctrl.imm : rt_data;

   // slt compares as two's complement
   assign less_signed = ($signed(rs_data) < $signed(op_b));

   always_comb
   begin
      case (ctrl.alu_op)
         mips_pkg::ALU_ADD:
            result = rs_data + op_b;
         mips_pkg::ALU_SUB:
            result = rs_data - op_b;
         mips_pkg::ALU_AND:
            result = rs_data & op_b;
         mips_pkg::ALU_OR:
            result = rs_data | op_b;
         mips_pkg::ALU_XOR:
            result = rs_data ^ op_b;
         mips_pkg::ALU_NOR:
            result = ~(rs_data | op_b);
         mips_pkg::ALU_SLT:
            result = {31'b0, less_signed};
         // shifts use rt and the shamt field only
         mips_pkg::ALU_SLL:
            result = rt_data << ctrl.shamt;
         mips_pkg::ALU_SRL:
            result = rt_data >> ctrl.shamt;
         mips_pkg::ALU_SRA:
            result = $signed(rt_data) >>> ctrl.shamt;
         // immediate to the upper half, low half cleared
         mips_pkg::ALU_LUI:
            result = {ctrl.imm[15:0], 16'h0000};
         default:
            result = rs_data + op_b;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/mips_decode.sv
// instruction decoder: splits fields and builds the control struct
`default_nettype none
`timescale 1ns/1ps

module mips_decode (
   input  mips_pkg::word_t    inst,
   output mips_pkg::ctrl_t    ctrl,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt
);

   mips_pkg::opcode_t  opcode;
   mips_pkg::funct_t   funct;
   mips_pkg::reg_idx_t rd;
   logic [15:0]        imm16;
   logic [25:0]        target;

   // fixed field positions
   assign opcode = inst[31:26];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];
   assign rd     = inst[15:11];
   assign funct  = inst[5:0];
   assign imm16  = inst[15:0];
   assign target = inst[25:0];

   always_comb
   begin
      // defaults: no write, no memory, sequential pc
      ctrl                 = '0;
      ctrl.alu_op          = mips_pkg::ALU_ADD;
      ctrl.pc_sel          = mips_pkg::PC_SEQ;
      ctrl.wr_reg          = rt;
      ctrl.shamt           = inst[10:6];
      ctrl.imm_sign_extend = 1'b1;

      case (opcode)
         mips_pkg::OP_RTYPE:
         begin
            ctrl.wr_reg    = rd;
            ctrl.reg_write = 1'b1;
            case (funct)
               mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
               // syscall and every unknown funct stop the core
               default:
               begin
                  ctrl.reg_write = 1'b0;
                  ctrl.halt_req  = 1'b1;
               end
            endcase
         end
         mips_pkg::OP_ADDIU:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI:
         begin
            ctrl.alu_op          = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                                                                    mips_pkg::ALU_OR;
            ctrl.alu_src_imm     = 1'b1;
            ctrl.imm_sign_extend = 1'b0;
            ctrl.reg_write       = 1'b1;
         end
         mips_pkg::OP_LUI:
         begin
            ctrl.alu_op          = mips_pkg::ALU_LUI;
            ctrl.alu_src_imm     = 1'b1;
            ctrl.imm_sign_extend = 1'b0;
            ctrl.reg_write       = 1'b1;
         end
         mips_pkg::OP_LW:
         begin
            // address is rs + signed offset
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         mips_pkg::OP_SW:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         mips_pkg::OP_BEQ: ctrl.pc_sel = mips_pkg::PC_BEQ;
         mips_pkg::OP_BNE: ctrl.pc_sel = mips_pkg::PC_BNE;
         mips_pkg::OP_J:   ctrl.pc_sel = mips_pkg::PC_JUMP;
         default:          ctrl.halt_req = 1'b1;
      endcase

      // j reuses the imm field for its target
      if (ctrl.pc_sel == mips_pkg::PC_JUMP)
         ctrl.imm = {6'b0, target};
      else if (ctrl.imm_sign_extend)
         ctrl.imm = {{16{imm16[15]}}, imm16};
      else
         ctrl.imm = {16'h0000, imm16};
   end

endmodule

`default_nettype wire

//--- verilog/mips_fetch.sv
// fetch stage: holds the pc, picks the next pc and keeps the sticky halt flag
`default_nettype none
`timescale 1ns/1ps

module mips_fetch #(
   parameter mips_pkg::word_t TEXT_START = 32'h0040_0000
) (
   input  wire                    clk,
   input  wire                    rst_b,
   input  mips_pkg::ctrl_t        ctrl,
   input  mips_pkg::word_t        rs_data,
   input  mips_pkg::word_t        rt_data,
   input  wire                    stall,
   output mips_pkg::word_addr_t   inst_addr,
   output logic                   halted
);

   mips_pkg::word_t pc;
   mips_pkg::word_t pc_plus4;
   mips_pkg::word_t branch_target;
   mips_pkg::word_t jump_target;
   mips_pkg::word_t pc_next;
   logic            regs_equal;
   logic            commit;

   assign pc_plus4 = pc + 32'd4;
   // offset is in words, relative to the following instruction
   assign branch_target = pc_plus4 + {ctrl.imm[29:0], 2'b00};
   // region bits come from pc+4
   assign jump_target = {pc_plus4[31:28], ctrl.imm[25:0], 2'b00};

   // beq/bne compare is done here, not in the alu
   assign regs_equal = (rs_data == rt_data);

   always_comb
   begin
      case (ctrl.pc_sel)
         mips_pkg::PC_BEQ:  pc_next = regs_equal ? branch_target : pc_plus4;
         mips_pkg::PC_BNE:  pc_next = regs_equal ? pc_plus4 : branch_target;
         mips_pkg::PC_JUMP: pc_next = jump_target;
         default:           pc_next = pc_plus4;
      endcase
   end

   // an instruction retires when memory is done and the core still runs
   assign commit = !stall && !halted;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc     <= TEXT_START;
         halted <= 1'b0;
      end
      else if (commit)
      begin
         // pc stays on the halting instruction
         if (ctrl.halt_req)
            halted <= 1'b1;
         else
            pc <= pc_next;
      end
   end

   assign inst_addr = pc[31:2];

   // once halted, only reset brings the core back
   halted_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else $error("halted dropped while out of reset");

endmodule

`default_nettype wire

//--- verilog/mips_mem_wb.sv
// memory and write-back: data memory request with valid/ready stall, write-back select
`default_nettype none
`timescale 1ns/1ps

module mips_mem_wb (
   input  wire                  clk,
   input  wire                  rst_b,
   input  mips_pkg::ctrl_t      ctrl,
   input  wire                  halted,
   input  mips_pkg::word_t      alu_result,
   input  mips_pkg::word_t      rt_data,
   output logic                 dmem_valid,
   output mips_pkg::dmem_req_t  dmem_req,
   input  wire                  dmem_ready,
   input  mips_pkg::word_t      dmem_rdata,
   output logic                 stall,
   output logic                 wr_en,
   output mips_pkg::word_t      wr_data
);

   logic mem_access;

   assign mem_access = ctrl.mem_read | ctrl.mem_write;

   // request goes out for lw/sw only out of reset and before the core stops
   assign dmem_valid = mem_access && !halted && rst_b;

   // word address from the alu sum, store data straight from rt
   assign dmem_req.addr  = alu_result[31:2];
   assign dmem_req.wdata = rt_data;
   assign dmem_req.write = ctrl.mem_write;

   // hold the whole core until the transfer cycle
   assign stall = dmem_valid && !dmem_ready;

   // write back only on the commit cycle
   assign wr_en   = ctrl.reg_write && !halted && !stall;
   assign wr_data = ctrl.mem_read ? dmem_rdata : alu_result;

   // frozen pc and registers must keep the request steady under back-pressure
   req_stable: assert property (@(posedge clk) disable iff (!rst_b)
      (dmem_valid && !dmem_ready) |=> (dmem_valid && $stable(dmem_req)))
      else $error("dmem request changed before ready");

endmodule

`default_nettype wire

//--- verilog/mips_regfile.sv
// general purpose register file, two read ports and one write port, r0 reads zero
`default_nettype none
`timescale 1ns/1ps

module mips_regfile (
   input  wire                clk,
   input  wire                rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  wire                wr_en,
   input  mips_pkg::reg_idx_t wr_reg,
   input  mips_pkg::word_t    wr_data,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);

   // r0 has no storage
   mips_pkg::word_t regs [1:31];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      else if (wr_en && (wr_reg != '0))
      begin
         regs[wr_reg] <= wr_data;
      end
   end

   // reads are combinational, no bypass needed in a single-cycle core
   assign rs_data = (rs == '0) ? '0 : regs[rs];
   assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
// single-cycle mips core top: fetch, decode, register file, alu and memory stage
`default_nettype none
`timescale 1ns/1ps

module mips_core #(
   parameter mips_pkg::word_t TEXT_START = 32'h0040_0000
) (
   input  wire                  clk,
   input  wire                  rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output logic                 dmem_valid,
   output mips_pkg::dmem_req_t  dmem_req,
   input  wire                  dmem_ready,
   input  mips_pkg::word_t      dmem_rdata,
   output logic                 halted
);

   mips_pkg::ctrl_t    ctrl;
   mips_pkg::reg_idx_t rs;
   mips_pkg::reg_idx_t rt;
   mips_pkg::word_t    rs_data;
   mips_pkg::word_t    rt_data;
   mips_pkg::word_t    alu_result;
   mips_pkg::word_t    wr_data;
   logic               stall;
   logic               wr_en;

   // pc and halt state
   mips_fetch #(
      .TEXT_START (TEXT_START)
   ) u_fetch (
      .clk       (clk),
      .rst_b     (rst_b),
      .ctrl      (ctrl),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .stall     (stall),
      .inst_addr (inst_addr),
      .halted    (halted)
   );

   mips_decode u_decode (
      .inst (inst),
      .ctrl (ctrl),
      .rs   (rs),
      .rt   (rt)
   );

   // destination comes from decode, enable and data from the memory stage
   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (rs),
      .rt      (rt),
      .wr_en   (wr_en),
      .wr_reg  (ctrl.wr_reg),
      .wr_data (wr_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu u_alu (
      .ctrl    (ctrl),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .result  (alu_result)
   );

   mips_mem_wb u_mem_wb (
      .clk        (clk),
      .rst_b      (rst_b),
      .ctrl       (ctrl),
      .halted     (halted),
      .alu_result (alu_result),
      .rt_data    (rt_data),
      .dmem_valid (dmem_valid),
      .dmem_req   (dmem_req),
      .dmem_ready (dmem_ready),
      .dmem_rdata (dmem_rdata),
      .stall      (stall),
      .wr_en      (wr_en),
      .wr_data    (wr_data)
   );

endmodule

`default_nettype wire

//--- verif/mips_ref_model.svh
// isa reference model and random program generator for the mips core testbench
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

   localparam int PROG_WORDS = 128;
   localparam int RAND_COUNT = 60;
   localparam int WIN_WORDS  = 64;

   // program image, data window preload and the expected bus traffic
   logic [31:0] imem [0:PROG_WORDS-1];
   logic [31:0] dmem_init [0:WIN_WORDS-1];
   logic [31:0] exp_pc [$];
   logic [31:0] exp_store_addr [$];
   logic [31:0] exp_store_data [$];
   logic [31:0] exp_load_addr [$];

   function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
      return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic build_program();
      logic [4:0]  a;
      logic [4:0]  b;
      logic [4:0]  d;
      logic [15:0] imm;
      logic [15:0] skip;
      int          kind;
      // unused slots hold syscalls whose code field is the slot index
      for (int i = 0; i < PROG_WORDS; i++)
         imem[i] = {6'h00, 20'(i), mips_pkg::FN_SYSCALL};
      for (int i = 0; i < WIN_WORDS; i++)
         dmem_init[i] = $urandom;
      for (int i = 0; i < RAND_COUNT; i++)
      begin
         a   = 5'($urandom);
         b   = 5'($urandom);
         d   = 5'($urandom);
         imm = 16'($urandom);
         // slot 0 has no memory access so the first cycle out of reset shows no request
         kind = (i == 0) ? int'($urandom % 11) : int'($urandom % 16);
         // target lands 1 to 4 words past the branch, never inside the tail
         skip = 16'($urandom % 4);
         if (i + 1 + int'(skip) > RAND_COUNT)
            skip = 16'(RAND_COUNT - 1 - i);
         case (kind)
            0:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_ADDU);
            1:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_SUBU);
            2:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_AND);
            3:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_OR);
            4:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_XOR);
            5:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_NOR);
            6:  imem[i] = enc_r(a, b, d, 5'd0, mips_pkg::FN_SLT);
            7:  imem[i] = enc_r(5'd0, b, d, a, imm[0] ? mips_pkg::FN_SRL :
                                (imm[1] ? mips_pkg::FN_SRA : mips_pkg::FN_SLL));
            8:  imem[i] = enc_i(mips_pkg::OP_ADDIU, a, b, imm);
            9:  imem[i] = enc_i(imm[15] ? mips_pkg::OP_ANDI : mips_pkg::OP_ORI, a, b, imm);
            10: imem[i] = enc_i(mips_pkg::OP_LUI, 5'd0, b, imm);
            // loads and stores stay inside the window, based on r0
            11, 12: imem[i] = enc_i(mips_pkg::OP_LW, 5'd0, b, {8'h00, imm[5:0], 2'b00});
            13: imem[i] = enc_i(mips_pkg::OP_SW, 5'd0, b, {8'h00, imm[5:0], 2'b00});
            // beq often compares a register with itself so it is taken too
            14: imem[i] = imm[0] ? enc_i(mips_pkg::OP_BNE, a, b, skip) :
                                   enc_i(mips_pkg::OP_BEQ, a, imm[1] ? a : b, skip);
            default:
               imem[i] = {mips_pkg::OP_J,
                          26'((TEXT_START >> 2) + 32'(i) + 32'd1 + 32'(skip))};
         endcase
      end
      // dump every register through the store path, then stop
      for (int r = 1; r < 32; r++)
         imem[RAND_COUNT + r - 1] = enc_i(mips_pkg::OP_SW, 5'd0, 5'(r), 16'(r * 4));
      imem[RAND_COUNT + 31] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::FN_SYSCALL);
   endtask

   task automatic run_model();
      logic [31:0] regs [0:31];
      logic [31:0] mem [0:WIN_WORDS-1];
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_s;
      logic [31:0] imm_z;
      logic [31:0] addr;
      logic [31:0] next;
      logic [4:0]  rd;
      logic [4:0]  rt;
      logic        stop;
      for (int r = 0; r < 32; r++)
         regs[r] = '0;
      for (int w = 0; w < WIN_WORDS; w++)
         mem[w] = dmem_init[w];
      pc   = TEXT_START;
      stop = 1'b0;
      while (!stop && exp_pc.size() < 200)
      begin
         ins   = imem[7'((pc - TEXT_START) >> 2)];
         rt    = ins[20:16];
         rd    = ins[15:11];
         a     = regs[ins[25:21]];
         b     = regs[rt];
         imm_s = {{16{ins[15]}}, ins[15:0]};
         imm_z = {16'h0000, ins[15:0]};
         addr  = a + imm_s;
         // no delay slot, branch offsets count from the next instruction
         next  = pc + 32'd4;
         case (ins[31:26])
            mips_pkg::OP_RTYPE:
               case (ins[5:0])
                  mips_pkg::FN_ADDU: regs[rd] = a + b;
                  mips_pkg::FN_SUBU: regs[rd] = a - b;
                  mips_pkg::FN_AND:  regs[rd] = a & b;
                  mips_pkg::FN_OR:   regs[rd] = a | b;
                  mips_pkg::FN_XOR:  regs[rd] = a ^ b;
                  mips_pkg::FN_NOR:  regs[rd] = ~(a | b);
                  mips_pkg::FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  mips_pkg::FN_SLL:  regs[rd] = b << ins[10:6];
                  mips_pkg::FN_SRL:  regs[rd] = b >> ins[10:6];
                  mips_pkg::FN_SRA:  regs[rd] = $signed(b) >>> ins[10:6];
                  default:           stop = 1'b1;
               endcase
            mips_pkg::OP_ADDIU: regs[rt] = a + imm_s;
            mips_pkg::OP_ANDI:  regs[rt] = a & imm_z;
            mips_pkg::OP_ORI:   regs[rt] = a | imm_z;
            mips_pkg::OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
            mips_pkg::OP_LW:
            begin
               exp_load_addr.push_back(addr >> 2);
               regs[rt] = mem[addr[7:2]];
            end
            mips_pkg::OP_SW:
            begin
               exp_store_addr.push_back(addr >> 2);
               exp_store_data.push_back(b);
               mem[addr[7:2]] = b;
            end
            mips_pkg::OP_BEQ: next = (a == b) ? next + (imm_s << 2) : next;
            mips_pkg::OP_BNE: next = (a != b) ? next + (imm_s << 2) : next;
            mips_pkg::OP_J:   next = {next[31:28], ins[25:0], 2'b00};
            default:          stop = 1'b1;
         endcase
         regs[0] = '0;
         // a halting instruction leaves the pc on itself
         if (stop)
            exp_pc.push_back(pc);
         else
         begin
            exp_pc.push_back(next);
            pc = next;
         end
      end
   endtask

`endif

//--- verif/tb_mips_core.sv
// testbench for the single-cycle mips core: random program checked against an isa model
`default_nettype none
`timescale 1ns/1ps

module tb_mips_core;

   localparam logic [31:0] TEXT_START  = 32'h0040_0000;
   // 100 instructions of up to 5 cycles each, plus slack
   localparam int          CYCLE_LIMIT = 100 * 5 + 50;
   // store of r1 to word 1 for cycles in which no request may go out
   localparam logic [31:0] PROBE_STORE = {mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0004};

   logic                 clk;
   logic                 rst_b;
   mips_pkg::word_addr_t inst_addr;
   mips_pkg::word_t      inst;
   logic                 dmem_valid;
   mips_pkg::dmem_req_t  dmem_req;
   logic                 dmem_ready;
   mips_pkg::word_t      dmem_rdata;
   logic                 halted;

   `include "mips_ref_model.svh"

   // environment data memory, written by store transfers
   logic [31:0]          dmem [0:WIN_WORDS-1];
   logic [31:0]          prog_idx;
   int                   errs [1:6];
   int                   n_checks;
   int                   n_commits;
   int                   n_stores;
   int                   n_loads;
   int                   model_stores;
   int                   model_loads;
   int                   cycles;
   int unsigned          wait_left;
   logic                 busy;
   logic                 running;
   logic                 mem_live;
   logic                 halt_seen;
   logic                 commit_prev;
   logic                 stall_prev;
   mips_pkg::dmem_req_t  held_req;
   mips_pkg::word_addr_t held_inst_addr;

   mips_core DUT (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_addr  (inst_addr),
      .inst       (inst),
      .dmem_valid (dmem_valid),
      .dmem_req   (dmem_req),
      .dmem_ready (dmem_ready),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   // combinational instruction memory, outside the image reads as syscall
   // a store sits on the bus while reset is held
   assign prog_idx = 32'(inst_addr) - (TEXT_START >> 2);
   assign inst     = !rst_b ? PROBE_STORE :
                     (prog_idx < 32'(PROG_WORDS)) ? imem[prog_idx[6:0]] :
                                                    {6'h00, 20'hfffff, mips_pkg::FN_SYSCALL};

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_word(input int id, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("[ERROR] test %0d %s: got 0x%08h expected 0x%08h", id, name, got, exp);
         errs[id]++;
      end
   endtask

   task automatic check_true(input int id, input logic ok, input string what);
      n_checks++;
      assert (ok)
      else
      begin
         $display("test %0d failure: %s", id, what);
         errs[id]++;
      end
   endtask

   task automatic check_reset_state();
      check_word(1, "halted", 32'(halted), 32'h0);
      check_word(1, "dmem_valid", 32'(dmem_valid), 32'h0);
      check_word(1, "inst_addr", 32'(inst_addr), TEXT_START >> 2);
   endtask

   task automatic check_transfer();
      if (dmem_req.write)
      begin
         if (exp_store_addr.size() == 0)
            check_true(3, 1'b0, "store transfer with no store left in the model");
         else
         begin
            check_word(3, "dmem_req.addr", 32'(dmem_req.addr), exp_store_addr.pop_front());
            check_word(3, "dmem_req.wdata", dmem_req.wdata, exp_store_data.pop_front());
         end
         dmem[dmem_req.addr[5:0]] = dmem_req.wdata;
         n_stores++;
      end
      else
      begin
         if (exp_load_addr.size() == 0)
            check_true(4, 1'b0, "load transfer with no load left in the model");
         else
            check_word(4, "dmem_req.addr", 32'(dmem_req.addr), exp_load_addr.pop_front());
         n_loads++;
      end
   endtask

   task automatic report_test(input int id, input string name);
      if (errs[id] == 0)
         $display("test %0d %s: pass", id, name);
      else
         $display("test %0d %s: fail with %0d errors", id, name, errs[id]);
   endtask

   // data memory responder, random wait of 0 to 3 cycles per request
   always @(posedge clk)
   begin
      #1;
      dmem_ready = 1'b0;
      if (mem_live && dmem_valid)
      begin
         if (!busy)
         begin
            busy      = 1'b1;
            wait_left = $urandom % 4;
         end
         if (wait_left == 0)
         begin
            dmem_ready = 1'b1;
            dmem_rdata = dmem[dmem_req.addr[5:0]];
            busy       = 1'b0;
         end
         else
            wait_left--;
      end
   end

   // monitor at the falling edge where every output has settled
   always @(negedge clk)
   begin
      if (running)
      begin
         cycles++;
         if (cycles > CYCLE_LIMIT)
         begin
            $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
         end
         else
         begin
            // pc after the previous commit must follow the model
            if (commit_prev)
            begin
               if (n_commits < exp_pc.size())
                  check_word(2, "inst_addr", 32'(inst_addr), exp_pc[n_commits] >> 2);
               else
                  check_true(2, 1'b0, "core committed more instructions than the model");
               n_commits++;
            end
            // a stalled cycle must leave request and pc untouched
            if (stall_prev)
            begin
               check_true(5, dmem_valid, "dmem_valid dropped before ready");
               check_word(5, "dmem_req.addr", 32'(dmem_req.addr), 32'(held_req.addr));
               check_word(5, "dmem_req.wdata", dmem_req.wdata, held_req.wdata);
               check_word(5, "dmem_req.write", 32'(dmem_req.write), 32'(held_req.write));
               check_word(5, "inst_addr", 32'(inst_addr), 32'(held_inst_addr));
            end
            if (dmem_valid && dmem_ready)
               check_transfer();
            stall_prev     = dmem_valid && !dmem_ready;
            commit_prev    = !halted && !stall_prev;
            held_req       = dmem_req;
            held_inst_addr = inst_addr;
            if (halted)
               halt_seen = 1'b1;
         end
      end
   end

   initial
   begin
      int                   total;
      mips_pkg::word_addr_t halt_addr;
      rst_b       = 1'b0;
      dmem_ready  = 1'b0;
      dmem_rdata  = '0;
      busy        = 1'b0;
      wait_left   = 0;
      running     = 1'b0;
      mem_live    = 1'b0;
      halt_seen   = 1'b0;
      commit_prev = 1'b0;
      stall_prev  = 1'b0;
      held_req    = '0;
      cycles      = 0;
      n_checks    = 0;
      n_commits   = 0;
      n_stores    = 0;
      n_loads     = 0;
      for (int i = 1; i <= 6; i++)
         errs[i] = 0;
      void'($urandom(38));
      build_program();
      for (int w = 0; w < WIN_WORDS; w++)
         dmem[w] = dmem_init[w];
      run_model();
      model_stores = exp_store_addr.size();
      model_loads  = exp_load_addr.size();

      // two cycles of reset, released just after a rising edge
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      #1;
      rst_b   = 1'b1;
      running = 1'b1;
      @(negedge clk);
      check_reset_state();
      mem_live = 1'b1;
      report_test(1, "reset state");

      while (!halt_seen)
         @(negedge clk);
      check_word(2, "commit count", 32'(n_commits), 32'(exp_pc.size()));
      check_word(4, "load count", 32'(n_loads), 32'(model_loads));
      check_word(5, "store count", 32'(n_stores), 32'(model_stores));
      report_test(2, "fetch order");
      report_test(3, "store traffic");
      report_test(4, "load path");
      report_test(5, "back-pressure");

      // core must stay parked after syscall
      check_word(6, "halted", 32'(halted), 32'h1);
      halt_addr = inst_addr;
      mem_live  = 1'b0;
      // the parked address now holds a store that must not go out
      @(posedge clk);
      #1;
      imem[prog_idx[6:0]] = PROBE_STORE;
      repeat (10)
      begin
         @(negedge clk);
         check_word(6, "halted", 32'(halted), 32'h1);
         check_word(6, "inst_addr", 32'(inst_addr), 32'(halt_addr));
         check_word(6, "dmem_valid", 32'(dmem_valid), 32'h0);
      end
      report_test(6, "halt");

      total = 0;
      for (int i = 1; i <= 6; i++)
         total += errs[i];
      $display("checks %0d, errors %0d, commits %0d, stores %0d, loads %0d",
               n_checks, total, n_commits, n_stores, n_loads);
      if (total == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
verilog/mips_pkg.sv
verilog/mips_alu.sv
verilog/mips_decode.sv
verilog/mips_fetch.sv
verilog/mips_mem_wb.sv
verilog/mips_regfile.sv
verilog/mips_core.sv
verif/tb_mips_core.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mips_core
FLIST      = flist.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
